/* verilog.f */
hw/button_pkg.sv
hw/switch_debounce.sv
hw/press_classify.sv
hw/press_event_queue.sv
hw/switch_press_top.sv
verif/switch_press_checker.sv
verif/switch_press_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the pushbutton front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module switch_press_tb \
    -f verilog.f -o switch_press_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/switch_press_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* verif/switch_press_tb.sv */
/*
 * Pushbutton front end testbench
 * Directed presses with driven bounce, a credit-returning consumer and event checks
 */

module switch_press_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int CREDIT_DELAY   = 3;

    logic                     clk           = 1'b0;
    logic                     arst_n        = 1'b0;
    logic                     switch_raw_n  = 1'b1;
    logic                     credit_return = 1'b0;
    logic                     evt_valid;
    logic                     overflow;
    button_pkg::press_event_t evt;

    // Received events and the cycles at which their credits fall due
    button_pkg::press_event_t rx_q[$];
    int                       credit_due_q[$];
    bit                       credits_on = 1'b1;
    int                       cycle_cnt  = 0;
    int                       err_cnt    = 0;
    // Own count of releases, source of the expected seq
    int                       rel_cnt    = 0;

    switch_press_top #(
        .DEBOUNCE_CYCLES   (8),
        .LONG_PRESS_CYCLES (64),
        .QUEUE_DEPTH       (4),
        .CREDITS           (2)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .switch_raw_n  (switch_raw_n),
        .evt_valid     (evt_valid),
        .evt           (evt),
        .credit_return (credit_return),
        .overflow      (overflow)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Consumer model
    // Outputs settle by the falling edge, each high cycle is one send
    always @(negedge clk)
    begin
        if (evt_valid)
        begin
            rx_q.push_back(evt);
            credit_due_q.push_back(cycle_cnt + CREDIT_DELAY);
        end
        if (credits_on && credit_due_q.size() != 0 && credit_due_q[0] <= cycle_cnt)
        begin
            credit_return = 1'b1;
            void'(credit_due_q.pop_front());
        end
        else
        begin
            credit_return = 1'b0;
        end
    end

    task automatic report_mismatch(input string what, input int exp, input int act);
        err_cnt++;
        $display("Fail %s: expected %0d, actual %0d", what, exp, act);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Random dwell of 1 to 5 cycles per toggle, well under the debounce window
    task automatic bounce_to(input logic level, input int toggles);
        repeat (toggles)
        begin
            switch_raw_n = ~switch_raw_n;
            idle($urandom_range(5, 1));
        end
        switch_raw_n = level;
    endtask

    // One press, then idle long enough for release debounce and the queue
    task automatic drive_press(input int hold, input int toggles);
        bounce_to(1'b0, toggles);
        idle(hold);
        bounce_to(1'b1, toggles);
        idle(20);
        rel_cnt++;
    endtask

    task automatic wait_events(input string name, input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < 200)
        begin
            @(negedge clk);
            waited++;
        end
        if (rx_q.size() < n)
        begin
            err_cnt++;
            $display("%s: event number %0d never arrived", name, n);
        end
    endtask

    // Exactly one new event, with the given kind and the next press number
    task automatic press_and_check(input string name, input int hold, input int toggles,
                                   input button_pkg::press_kind_t kind);
        int n;
        int exp_seq;
        n       = rx_q.size();
        exp_seq = rel_cnt % 256;
        drive_press(hold, toggles);
        wait_events(name, n + 1);
        idle(10);
        if (rx_q.size() != n + 1)
            report_mismatch({name, " count"}, n + 1, rx_q.size());
        if (rx_q.size() > n)
        begin
            if (rx_q[n].kind != kind)
                report_mismatch({name, " kind"}, int'(kind), int'(rx_q[n].kind));
            if (int'(rx_q[n].seq) != exp_seq)
                report_mismatch({name, " seq"}, exp_seq, int'(rx_q[n].seq));
        end
    endtask

    // Five clock edges in reset, outputs quiet throughout and after
    task automatic reset_outputs();
        repeat (5)
        begin
            @(negedge clk);
            if (evt_valid || overflow)
                report_mismatch("reset outputs", 0, int'({evt_valid, overflow}));
        end
        arst_n = 1'b1;
        idle(2);
        if (evt_valid || overflow)
            report_mismatch("post reset outputs", 0, int'({evt_valid, overflow}));
    endtask

    // First event after reset, so seq 0
    task automatic short_press();
        press_and_check("short_press", 30, 0, button_pkg::PRESS_SHORT);
    endtask

    task automatic long_press();
        press_and_check("long_press", 120, 0, button_pkg::PRESS_LONG);
    endtask

    // Lone glitches first, then a press bouncing at both ends
    task automatic glitch_and_bounce();
        int n;
        n = rx_q.size();
        repeat (3)
        begin
            switch_raw_n = 1'b0;
            idle($urandom_range(5, 1));
            switch_raw_n = 1'b1;
            idle(30);
        end
        if (rx_q.size() != n)
            report_mismatch("bounce_glitch count", n, rx_q.size());
        press_and_check("bounce_press", 30, 4, button_pkg::PRESS_SHORT);
    endtask

    // Two sends, four queued, seventh dropped
    task automatic credit_overflow();
        int n;
        int base;
        while (credit_due_q.size() != 0)
            @(negedge clk);
        credits_on = 1'b0;
        n          = rx_q.size();
        base       = rel_cnt;
        repeat (7)
            drive_press(30, 0);
        idle(20);
        if (rx_q.size() != n + 2)
            report_mismatch("overflow held count", n + 2, rx_q.size());
        if (!overflow)
            report_mismatch("overflow flag", 1, 0);
        credits_on = 1'b1;
        wait_events("overflow_drain", n + 6);
        idle(30);
        if (rx_q.size() != n + 6)
            report_mismatch("overflow_drain count", n + 6, rx_q.size());
        for (int i = 0; i < 6 && n + i < rx_q.size(); i++)
            if (int'(rx_q[n + i].seq) != (base + i) % 256)
                report_mismatch("overflow_drain seq", (base + i) % 256, int'(rx_q[n + i].seq));
        // Dropped press still consumed its number
        press_and_check("after_drop", 30, 0, button_pkg::PRESS_SHORT);
    endtask

    initial
    begin
        void'($urandom(32'h7537_36c0));
        reset_outputs();
        short_press();
        long_press();
        glitch_and_bounce();
        credit_overflow();
        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Run limit, the tests take about 2000 cycles
    initial
    begin
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verif/switch_press_checker.sv */
/*
 * Credit and event protocol assertions, bound to the press event queue
 */

module switch_press_checker #(
    parameter int CREDITS     = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input logic                               clk,
    input logic                               arst_n,
    input logic                               press_valid,
    input logic                               evt_valid,
    input logic                               credit_return,
    input logic                               overflow,
    input logic [$clog2(CREDITS + 1)-1:0]     credit_cnt,
    input logic [$clog2(QUEUE_DEPTH + 1)-1:0] occupancy
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CRD_W = $clog2(CREDITS + 1);
    localparam int OCC_W = $clog2(QUEUE_DEPTH + 1);

    // Sends still waiting for their credit to come back
    logic [CRD_W-1:0] in_flight;

    // Consumer side view of the slots in use
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_flight <= '0;
        end
        else if (evt_valid && !credit_return)
        begin
            in_flight <= in_flight + CRD_W'(1);
        end
        else if (credit_return && !evt_valid && (in_flight != '0))
        begin
            in_flight <= in_flight - CRD_W'(1);
        end
    end

    // No send while every consumer slot is taken
    no_send_without_credit: assert property (@(posedge clk) disable iff (!arst_n)
        evt_valid |-> (in_flight < CRD_W'(CREDITS)))
        else $error("evt_valid high with every consumer slot taken");

    // Credit count bounded by the consumer buffer
    credit_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= CRD_W'(CREDITS))
        else $error("credit count above CREDITS");

    // Sticky drop flag
    overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        !$fell(overflow))
        else $error("overflow fell outside reset");

    // Back-to-back sends need a second credit and a second entry
    back_to_back_send: assert property (@(posedge clk) disable iff (!arst_n)
        evt_valid |=> (!evt_valid
            || ((($past(credit_cnt) > CRD_W'(1)) || $past(credit_return))
            && (($past(occupancy) > OCC_W'(1)) || $past(press_valid)))))
        else $error("evt_valid held without credit or data for a second send");

endmodule

bind press_event_queue switch_press_checker #(
    .CREDITS     (CREDITS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
) checker_i (.*);

/* hw/switch_press_top.sv */
/*
 * Pushbutton front end top level
 * Debounce, press classification and credit-controlled event queue
 */

module switch_press_top #(
    parameter int DEBOUNCE_CYCLES   = 8,
    parameter int LONG_PRESS_CYCLES = 64,
    parameter int QUEUE_DEPTH       = 4,
    parameter int CREDITS           = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     switch_raw_n,
    output logic                     evt_valid,
    output button_pkg::press_event_t evt,
    input  logic                     credit_return,
    output logic                     overflow
);

    logic                     pressed;
    logic                     press_valid;
    button_pkg::press_event_t press;

    // Raw line to clean level
    switch_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) debounce_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .switch_raw_n (switch_raw_n),
        .pressed      (pressed)
    );

    // Clean level to numbered events
    press_classify #(
        .LONG_PRESS_CYCLES (LONG_PRESS_CYCLES)
    ) classify_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .pressed     (pressed),
        .press_valid (press_valid),
        .press       (press)
    );

    // Events to the consumer
    press_event_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .CREDITS     (CREDITS)
    ) queue_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .press_valid   (press_valid),
        .press         (press),
        .evt_valid     (evt_valid),
        .evt           (evt),
        .credit_return (credit_return),
        .overflow      (overflow)
    );

endmodule

/* hw/press_event_queue.sv */
/*
 * Press event queue
 * Circular FIFO of press events, sent to the consumer under credit flow control
 */

module press_event_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDITS     = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     press_valid,
    input  button_pkg::press_event_t press,
    output logic                     evt_valid,
    output button_pkg::press_event_t evt,
    input  logic                     credit_return,
    output logic                     overflow
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int OCC_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    button_pkg::press_event_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occupancy;
    logic [CRD_W-1:0] credit_cnt;
    logic             full;
    logic             wr_en;
    logic             send;

    assign full  = (occupancy == OCC_W'(QUEUE_DEPTH));
    assign wr_en = press_valid & ~full;

    // Head goes out whenever data and a consumer slot are both there
    assign send      = (occupancy != '0) && (credit_cnt != '0);
    assign evt_valid = send;
    assign evt       = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= press;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (send)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
        end
    end

    // Occupancy, push and pop together cancel
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            occupancy <= '0;
        end
        else if (wr_en && !send)
        begin
            occupancy <= occupancy + OCC_W'(1);
        end
        else if (send && !wr_en)
        begin
            occupancy <= occupancy - OCC_W'(1);
        end
    end

    // Credits toward the consumer
    // Starts full, a return beyond CREDITS is ignored
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            credit_cnt <= CRD_W'(CREDITS);
        end
        else if (send && !credit_return)
        begin
            credit_cnt <= credit_cnt - CRD_W'(1);
        end
        else if (credit_return && !send && (credit_cnt != CRD_W'(CREDITS)))
        begin
            credit_cnt <= credit_cnt + CRD_W'(1);
        end
    end

    // Sticky drop flag, only reset clears it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            overflow <= 1'b0;
        end
        else if (press_valid && full)
        begin
            overflow <= 1'b1;
        end
    end

endmodule

/* hw/press_classify.sv */
/*
 * Press classifier
 * Times each debounced hold and emits one numbered short or long event per release
 */

module press_classify #(
    parameter int LONG_PRESS_CYCLES = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    pressed,
    output logic                    press_valid,
    output button_pkg::press_event_t press
);

    // Hold counter saturates at the long threshold
    localparam int HOLD_W = $clog2(LONG_PRESS_CYCLES + 1);

    logic                         pressed_q;
    logic [HOLD_W-1:0]            hold_cnt;
    logic                         hold_full;
    logic                         release_seen;
    logic [button_pkg::SEQ_W-1:0] seq_cnt;

    assign hold_full = (hold_cnt == HOLD_W'(LONG_PRESS_CYCLES));

    // Falling edge of the debounced level
    assign release_seen = pressed_q & ~pressed;

    // Previous level for edge detection
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pressed_q <= 1'b0;
        end
        else
        begin
            pressed_q <= pressed;
        end
    end

    // Count held cycles, stop at the threshold
    // Cleared while released, so each press starts from zero
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hold_cnt <= '0;
        end
        else if (!pressed)
        begin
            hold_cnt <= '0;
        end
        else if (!hold_full)
        begin
            hold_cnt <= hold_cnt + HOLD_W'(1);
        end
    end

    // Event strobe and press number
    // Number advances on every release, wraps at 256
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            press_valid <= 1'b0;
            seq_cnt     <= '0;
        end
        else
        begin
            press_valid <= release_seen;
            if (release_seen)
            begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // Event payload, only meaningful with press_valid
    always_ff @(posedge clk)
    begin
        if (release_seen)
        begin
            press.kind <= hold_full ? button_pkg::PRESS_LONG : button_pkg::PRESS_SHORT;
            press.seq  <= seq_cnt;
        end
    end

endmodule

/* hw/switch_debounce.sv */
/*
 * Switch debounce
 * Synchronizes the raw active-low switch and accepts a level only after it is stable
 */

module switch_debounce #(
    parameter int DEBOUNCE_CYCLES = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic switch_raw_n,
    output logic pressed
);

    // Counter has to hold DEBOUNCE_CYCLES itself
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             sync_meta;
    logic             sync_n;
    logic             raw_level;
    logic [CNT_W-1:0] stable_cnt;
    logic             differs;
    logic             settled;

    // Two-flop synchronizer
    // Both flops come up released, the line idles high
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_meta <= 1'b1;
            sync_n    <= 1'b1;
        end
        else
        begin
            sync_meta <= switch_raw_n;
            sync_n    <= sync_meta;
        end
    end

    // High while the switch is held
    assign raw_level = ~sync_n;

    // Candidate level disagrees with the accepted one
    assign differs = (raw_level != pressed);

    // Enough stable cycles seen
    assign settled = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

    // Stability counter
    // Any return to agreement throws the count away, so a bounce restarts it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stable_cnt <= '0;
            pressed    <= 1'b0;
        end
        else if (!differs)
        begin
            stable_cnt <= '0;
        end
        else if (settled)
        begin
            // Accept new level, start fresh for the next change
            pressed    <= raw_level;
            stable_cnt <= '0;
        end
        else
        begin
            stable_cnt <= stable_cnt + CNT_W'(1);
        end
    end

endmodule

/* hw/button_pkg.sv */
/*
 * Pushbutton front end shared types
 * Press kind and the numbered press event carried from classifier to consumer
 */

package button_pkg;

    // Width of the running press number
    localparam int SEQ_W = 8;

    // Outcome of one press, decided at release
    typedef enum logic {
        PRESS_SHORT = 1'b0,
        PRESS_LONG  = 1'b1
    } press_kind_t;

    // One classified press
    // Kind sits in the top bit, press number below it
    typedef struct packed {
        press_kind_t      kind;
        logic [SEQ_W-1:0] seq;
    } press_event_t;

endpackage
